// ==== hdl/bank_if.sv ====
// Bank interface
// Connects the conflict controller to one single-port physical bank.
// The controller issues op, row address and write data; the bank returns
// read data one cycle after a read op

interface bank_if;

  mem_types_pkg::bank_op_e              op;
  logic [mem_cfg_pkg::row_bits-1:0]     addr;
  logic [mem_cfg_pkg::data_width-1:0]   din;
  logic [mem_cfg_pkg::data_width-1:0]   dout;

  modport ctrl (
    output op,
    output addr,
    output din,
    input  dout
  );

  modport bank (
    input  op,
    input  addr,
    input  din,
    output dout
  );

endinterface

// ==== hdl/mem_1r1w_top.sv ====
// Remapped 1R1W memory, top level
// 64 words of 32 bits held in five single-port banks. A remap table
// and a conflict controller let one read and one write run each cycle

module mem_1r1w_top (
  input  logic                                clk,
  input  logic                                reset,
  output logic                                ready,
  input  logic                                write,
  input  logic [mem_cfg_pkg::addr_bits-1:0]   wr_adr,
  input  logic [mem_cfg_pkg::data_width-1:0]  din,
  input  logic                                read,
  input  logic [mem_cfg_pkg::addr_bits-1:0]   rd_adr,
  output logic                                rd_vld,
  output logic [mem_cfg_pkg::data_width-1:0]  rd_dout,
  output logic [mem_cfg_pkg::padr_bits-1:0]   rd_padr
);

  logic [mem_cfg_pkg::row_bits-1:0]    rd_row;
  logic [mem_cfg_pkg::row_bits-1:0]    wr_row;
  logic [mem_cfg_pkg::vbank_bits-1:0]  rd_vbank;
  logic [mem_cfg_pkg::vbank_bits-1:0]  wr_vbank;
  logic [mem_cfg_pkg::pbank_bits-1:0]  rd_pbank;
  logic [mem_cfg_pkg::pbank_bits-1:0]  wr_pbank;
  logic [mem_cfg_pkg::pbank_bits-1:0]  free_pbank;
  logic                                relocate;

  bank_if banks [mem_cfg_pkg::num_pbanks] ();

  remap_table u_table (
    .clk        (clk),
    .reset      (reset),
    .ready      (ready),
    .rd_row     (rd_row),
    .wr_row     (wr_row),
    .rd_vbank   (rd_vbank),
    .wr_vbank   (wr_vbank),
    .rd_pbank   (rd_pbank),
    .wr_pbank   (wr_pbank),
    .free_pbank (free_pbank),
    .relocate   (relocate)
  );

  rw_conflict_ctrl u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .ready      (ready),
    .write      (write),
    .read       (read),
    .wr_adr     (wr_adr),
    .rd_adr     (rd_adr),
    .din        (din),
    .rd_vld     (rd_vld),
    .rd_dout    (rd_dout),
    .rd_padr    (rd_padr),
    .rd_row     (rd_row),
    .wr_row     (wr_row),
    .rd_vbank   (rd_vbank),
    .wr_vbank   (wr_vbank),
    .rd_pbank   (rd_pbank),
    .wr_pbank   (wr_pbank),
    .free_pbank (free_pbank),
    .relocate   (relocate),
    .banks      (banks)
  );

  for (genvar b = 0; b < mem_cfg_pkg::num_pbanks; b++) begin : g_bank
    sp_bank u_bank (
      .clk  (clk),
      .port (banks[b])
    );
  end

endmodule

// ==== hdl/mem_cfg_pkg.sv ====
// Memory geometry package
// Shared sizes for the remapped 1R1W memory: word width, address split,
// and the number of virtual and physical banks

package mem_cfg_pkg;

  // Data word
  localparam int data_width = 32;

  // Logical address, split as {row, vbank}
  localparam int addr_bits  = 6;
  localparam int num_rows   = 16;
  localparam int row_bits   = 4;
  localparam int num_vbanks = 4;
  localparam int vbank_bits = 2;

  // Physical banks, one spare per row
  localparam int num_pbanks = 5;
  localparam int pbank_bits = 3;

  // rd_padr carries {physical bank, row}
  localparam int padr_bits  = pbank_bits + row_bits;

endpackage

// ==== hdl/mem_types_pkg.sv ====
// Type package for the remapped 1R1W memory
// State of the remap table and the operation driven onto a bank

package mem_types_pkg;

  // Table init sweep, then normal operation
  typedef enum logic {
    tbl_init,
    tbl_run
  } table_state_e;

  // Per-cycle operation on one single-port bank
  typedef enum logic [1:0] {
    bank_idle,
    bank_read,
    bank_write
  } bank_op_e;

endpackage

// ==== hdl/remap_table.sv ====
// Bank remap table
// Qualifies the external reset, sweeps all rows to the identity map on
// reset, then maps {row, vbank} to a physical bank for the read and the
// write. Each row also tracks its free physical bank. On a relocated
// write the write's entry and the free bank swap places

module remap_table (
  input  logic                                clk,
  input  logic                                reset,
  output logic                                ready,
  input  logic [mem_cfg_pkg::row_bits-1:0]    rd_row,
  input  logic [mem_cfg_pkg::row_bits-1:0]    wr_row,
  input  logic [mem_cfg_pkg::vbank_bits-1:0]  rd_vbank,
  input  logic [mem_cfg_pkg::vbank_bits-1:0]  wr_vbank,
  output logic [mem_cfg_pkg::pbank_bits-1:0]  rd_pbank,
  output logic [mem_cfg_pkg::pbank_bits-1:0]  wr_pbank,
  output logic [mem_cfg_pkg::pbank_bits-1:0]  free_pbank,
  input  logic                                relocate
);

  logic                                reset_d1;
  logic                                rst_int;
  mem_types_pkg::table_state_e         state;
  logic [mem_cfg_pkg::row_bits-1:0]    init_row;

  // Per-row map of virtual to physical bank, plus the spare bank
  logic [mem_cfg_pkg::pbank_bits-1:0]  map_q  [mem_cfg_pkg::num_rows][mem_cfg_pkg::num_vbanks];
  logic [mem_cfg_pkg::pbank_bits-1:0]  free_q [mem_cfg_pkg::num_rows];

  // Reset must be seen on two consecutive edges
  always_ff @(posedge clk) begin
    reset_d1 <= reset;
    rst_int  <= reset_d1 && reset;
  end

  always_ff @(posedge clk) begin
    if (rst_int) begin
      state    <= mem_types_pkg::tbl_init;
      init_row <= '0;
    end else if (state == mem_types_pkg::tbl_init) begin
      init_row <= init_row + 1'b1;
      if (init_row == mem_cfg_pkg::row_bits'(mem_cfg_pkg::num_rows - 1)) begin
        state <= mem_types_pkg::tbl_run;
      end
    end
  end

  assign ready = (state == mem_types_pkg::tbl_run);

  // Map storage, one row per cycle during the sweep
  always_ff @(posedge clk) begin
    if (state == mem_types_pkg::tbl_init) begin
      for (int v = 0; v < mem_cfg_pkg::num_vbanks; v++) begin
        map_q[init_row][v] <= mem_cfg_pkg::pbank_bits'(v);
      end
      free_q[init_row] <= mem_cfg_pkg::pbank_bits'(mem_cfg_pkg::num_pbanks - 1);
    end else if (relocate) begin
      // Write moved to the spare, its old bank becomes the spare
      map_q[wr_row][wr_vbank] <= free_q[wr_row];
      free_q[wr_row]          <= map_q[wr_row][wr_vbank];
    end
  end

  // Lookups without a clock
  assign rd_pbank   = map_q[rd_row][rd_vbank];
  assign wr_pbank   = map_q[wr_row][wr_vbank];
  assign free_pbank = free_q[wr_row];

endmodule

// ==== hdl/rw_conflict_ctrl.sv ====
// Read/write conflict controller
// Splits both addresses into row and virtual bank, takes the physical
// banks from the remap table and drives the five banks. A write that
// hits the same physical bank as the read goes to the row's free bank.
// Read data returns one cycle later with its physical address

module rw_conflict_ctrl (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                ready,
  input  logic                                write,
  input  logic                                read,
  input  logic [mem_cfg_pkg::addr_bits-1:0]   wr_adr,
  input  logic [mem_cfg_pkg::addr_bits-1:0]   rd_adr,
  input  logic [mem_cfg_pkg::data_width-1:0]  din,
  output logic                                rd_vld,
  output logic [mem_cfg_pkg::data_width-1:0]  rd_dout,
  output logic [mem_cfg_pkg::padr_bits-1:0]   rd_padr,
  output logic [mem_cfg_pkg::row_bits-1:0]    rd_row,
  output logic [mem_cfg_pkg::row_bits-1:0]    wr_row,
  output logic [mem_cfg_pkg::vbank_bits-1:0]  rd_vbank,
  output logic [mem_cfg_pkg::vbank_bits-1:0]  wr_vbank,
  input  logic [mem_cfg_pkg::pbank_bits-1:0]  rd_pbank,
  input  logic [mem_cfg_pkg::pbank_bits-1:0]  wr_pbank,
  input  logic [mem_cfg_pkg::pbank_bits-1:0]  free_pbank,
  output logic                                relocate,
  bank_if.ctrl                                banks [mem_cfg_pkg::num_pbanks]
);

  logic                                rd_acc;
  logic                                wr_acc;
  logic [mem_cfg_pkg::pbank_bits-1:0]  wr_target;
  logic [mem_cfg_pkg::pbank_bits-1:0]  rd_pbank_q;
  logic [mem_cfg_pkg::row_bits-1:0]    rd_row_q;
  logic [mem_cfg_pkg::data_width-1:0]  bank_dout [mem_cfg_pkg::num_pbanks];

  // Upper bits select the row, lower bits the virtual bank
  assign rd_row   = rd_adr[mem_cfg_pkg::addr_bits-1:mem_cfg_pkg::vbank_bits];
  assign rd_vbank = rd_adr[mem_cfg_pkg::vbank_bits-1:0];
  assign wr_row   = wr_adr[mem_cfg_pkg::addr_bits-1:mem_cfg_pkg::vbank_bits];
  assign wr_vbank = wr_adr[mem_cfg_pkg::vbank_bits-1:0];

  // Commands count only once the table is up
  assign rd_acc = read && ready;
  assign wr_acc = write && ready;

  assign relocate  = rd_acc && wr_acc && (rd_pbank == wr_pbank);
  assign wr_target = relocate ? free_pbank : wr_pbank;

  // The free bank never equals a mapped bank, so read and write
  // never land on one bank in the same cycle
  for (genvar b = 0; b < mem_cfg_pkg::num_pbanks; b++) begin : g_bank
    always_comb begin
      banks[b].op   = mem_types_pkg::bank_idle;
      banks[b].addr = '0;
      banks[b].din  = din;
      if (rd_acc && (rd_pbank == mem_cfg_pkg::pbank_bits'(b))) begin
        banks[b].op   = mem_types_pkg::bank_read;
        banks[b].addr = rd_row;
      end else if (wr_acc && (wr_target == mem_cfg_pkg::pbank_bits'(b))) begin
        banks[b].op   = mem_types_pkg::bank_write;
        banks[b].addr = wr_row;
      end
    end

    assign bank_dout[b] = banks[b].dout;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= rd_acc;
    end
  end

  // Remember where the read went, for the return mux and rd_padr
  always_ff @(posedge clk) begin
    if (rd_acc) begin
      rd_pbank_q <= rd_pbank;
      rd_row_q   <= rd_row;
    end
  end

  assign rd_dout = bank_dout[rd_pbank_q];
  assign rd_padr = {rd_pbank_q, rd_row_q};

endmodule

// ==== hdl/sp_bank.sv ====
// Single-port physical bank
// 16 rows of one data word each. One operation per cycle: a write
// stores the word at the edge, a read presents the word on dout
// after the next edge

module sp_bank (
  input logic clk,
  bank_if.bank port
);

  logic [mem_cfg_pkg::data_width-1:0] mem [mem_cfg_pkg::num_rows];

  always_ff @(posedge clk) begin
    if (port.op == mem_types_pkg::bank_write) begin
      mem[port.addr] <= port.din;
    end
  end

  // Registered read, dout holds until the next read
  always_ff @(posedge clk) begin
    if (port.op == mem_types_pkg::bank_read) begin
      port.dout <= mem[port.addr];
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the 1R1W memory testbench with Verilator, then judge the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps -f src.f \
  --top-module mem_1r1w_tb -o mem_1r1w_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/mem_1r1w_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
  exit 0
fi
exit 1

// ==== src.f ====
hdl/mem_cfg_pkg.sv
hdl/mem_types_pkg.sv
hdl/bank_if.sv
hdl/sp_bank.sv
hdl/remap_table.sv
hdl/rw_conflict_ctrl.sv
hdl/mem_1r1w_top.sv
verification/mem_1r1w_checker.sv
verification/mem_1r1w_tb.sv

// ==== verification/mem_1r1w_checker.sv ====
// Checker for the remapped 1R1W memory
// Keeps a reference model of the 64 words, the per-row bank map and the
// free bank, and compares ready, rd_vld, rd_dout and rd_padr every cycle

module mem_1r1w_checker (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                ready,
  input  logic                                write,
  input  logic [mem_cfg_pkg::addr_bits-1:0]   wr_adr,
  input  logic [mem_cfg_pkg::data_width-1:0]  din,
  input  logic                                read,
  input  logic [mem_cfg_pkg::addr_bits-1:0]   rd_adr,
  input  logic                                rd_vld,
  input  logic [mem_cfg_pkg::data_width-1:0]  rd_dout,
  input  logic [mem_cfg_pkg::padr_bits-1:0]   rd_padr,
  output int                                  errors,
  output int                                  checks
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_words = mem_cfg_pkg::num_rows * mem_cfg_pkg::num_vbanks;

  logic [mem_cfg_pkg::data_width-1:0]  mem_m     [num_words];
  logic                                mem_valid [num_words];
  logic [mem_cfg_pkg::pbank_bits-1:0]  map_m     [mem_cfg_pkg::num_rows][mem_cfg_pkg::num_vbanks];
  logic [mem_cfg_pkg::pbank_bits-1:0]  free_m    [mem_cfg_pkg::num_rows];
  mem_types_pkg::table_state_e         exp_state = mem_types_pkg::tbl_init;
  logic                                q_d1 = 1'b0;
  logic                                q_int = 1'b0;
  logic                                armed = 1'b0;
  int                                  init_cnt = 0;
  logic                                exp_ready = 1'b0;
  logic                                exp_vld = 1'b0;
  logic                                exp_known = 1'b0;
  logic [mem_cfg_pkg::data_width-1:0]  exp_dout = '0;
  logic [mem_cfg_pkg::padr_bits-1:0]   exp_padr = '0;

  initial begin
    errors = 0;
    checks = 0;
  end

  function automatic void compare_value(input string name,
                                        input logic [mem_cfg_pkg::data_width-1:0] got,
                                        input logic [mem_cfg_pkg::data_width-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endfunction

  // Outputs are stable at the falling edge, inputs are those of the next rising edge
  always @(negedge clk) begin
    logic [mem_cfg_pkg::row_bits-1:0]    rrow;
    logic [mem_cfg_pkg::row_bits-1:0]    wrow;
    logic [mem_cfg_pkg::vbank_bits-1:0]  rvb;
    logic [mem_cfg_pkg::vbank_bits-1:0]  wvb;
    logic [mem_cfg_pkg::pbank_bits-1:0]  old_bank;
    logic                                rd_ok;
    logic                                wr_ok;
    if (armed) begin
      checks++;
      if (ready !== exp_ready) begin
        errors++;
        $display("Error ready: got 0x%h, expected 0x%h, model state %s at %0t",
                 ready, exp_ready, exp_state.name(), $time);
      end
      compare_value("rd_vld", 32'(rd_vld), 32'(exp_vld));
      if (exp_vld) begin
        if (exp_known) compare_value("rd_dout", rd_dout, exp_dout);
        compare_value("rd_padr", 32'(rd_padr), 32'(exp_padr));
      end
    end
    rrow  = rd_adr[mem_cfg_pkg::addr_bits-1:mem_cfg_pkg::vbank_bits];
    rvb   = rd_adr[mem_cfg_pkg::vbank_bits-1:0];
    wrow  = wr_adr[mem_cfg_pkg::addr_bits-1:mem_cfg_pkg::vbank_bits];
    wvb   = wr_adr[mem_cfg_pkg::vbank_bits-1:0];
    rd_ok = read && exp_ready;
    wr_ok = write && exp_ready;
    exp_vld = !reset && rd_ok;
    // Read sees the word before this cycle's write
    if (rd_ok) begin
      exp_dout  = mem_m[rd_adr];
      exp_known = mem_valid[rd_adr];
      exp_padr  = {map_m[rrow][rvb], rrow};
    end
    if (wr_ok) begin
      if (rd_ok && (map_m[rrow][rvb] == map_m[wrow][wvb])) begin
        old_bank         = map_m[wrow][wvb];
        map_m[wrow][wvb] = free_m[wrow];
        free_m[wrow]     = old_bank;
      end
      mem_m[wr_adr]     = din;
      mem_valid[wr_adr] = 1'b1;
    end
    // Qualified reset restarts the sweep, which takes one row per cycle
    if (q_int) begin
      armed     = 1'b1;
      init_cnt  = 0;
      exp_state = mem_types_pkg::tbl_init;
      foreach (map_m[r, v]) map_m[r][v] = mem_cfg_pkg::pbank_bits'(v);
      foreach (free_m[r]) free_m[r] = mem_cfg_pkg::pbank_bits'(mem_cfg_pkg::num_pbanks - 1);
      foreach (mem_valid[a]) mem_valid[a] = 1'b0;
    end else if (init_cnt < mem_cfg_pkg::num_rows) begin
      init_cnt++;
      if (init_cnt == mem_cfg_pkg::num_rows) exp_state = mem_types_pkg::tbl_run;
    end
    exp_ready = (exp_state == mem_types_pkg::tbl_run);
    q_int = q_d1 && reset;
    q_d1  = reset;
  end

endmodule

// ==== verification/mem_1r1w_tb.sv ====
// Testbench for the remapped 1R1W memory
// Resets the DUT, issues commands before ready, then applies a table of
// reads and writes and a random tail. A checker module compares results

module mem_1r1w_tb;
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic                                rd_en;
    logic [mem_cfg_pkg::addr_bits-1:0]   rd_adr;
    logic                                wr_en;
    logic [mem_cfg_pkg::addr_bits-1:0]   wr_adr;
    logic [mem_cfg_pkg::data_width-1:0]  din;
  } stim_t;

  logic                                clk = 1'b0;
  logic                                reset;
  logic                                ready;
  logic                                write;
  logic                                read;
  logic                                rd_vld;
  logic [mem_cfg_pkg::addr_bits-1:0]   wr_adr;
  logic [mem_cfg_pkg::addr_bits-1:0]   rd_adr;
  logic [mem_cfg_pkg::data_width-1:0]  din;
  logic [mem_cfg_pkg::data_width-1:0]  rd_dout;
  logic [mem_cfg_pkg::padr_bits-1:0]   rd_padr;
  int                                  error_cnt;
  int                                  check_cnt;
  int                                  cycle_cnt = 0;
  int                                  cycle_limit = 1000;
  stim_t                               stim [$];

  always #50 clk = ~clk;

  mem_1r1w_top DUT (.*);

  mem_1r1w_checker u_checker (.*, .errors(error_cnt), .checks(check_cnt));

  function automatic logic [31:0] data_for(input int a);
    return {8'ha5, 2'b00, 6'(a), 8'h5a, 2'b00, 6'(~a)};
  endfunction

  function automatic void add_entry(input logic re, input logic [5:0] ra, input logic we,
                                    input logic [5:0] wa, input logic [31:0] d);
    stim.push_back({re, ra, we, wa, d});
  endfunction

  function automatic void fill_table();
    for (int a = 0; a < 64; a++) add_entry(1'b0, '0, 1'b1, 6'(a), data_for(a));
    for (int a = 0; a < 64; a++) add_entry(1'b1, 6'(a), 1'b0, '0, '0);
    // Both writes share a physical bank with the read in another row
    add_entry(1'b1, 6'd0, 1'b1, 6'd4, 32'h4444_0004);
    add_entry(1'b1, 6'd9, 1'b1, 6'd13, 32'h1313_000d);
    add_entry(1'b1, 6'd4, 1'b0, '0, '0);
    add_entry(1'b1, 6'd13, 1'b0, '0, '0);
    // Same address returns the old word first
    add_entry(1'b1, 6'd20, 1'b1, 6'd20, 32'h2020_0014);
    add_entry(1'b1, 6'd20, 1'b0, '0, '0);
    for (int a = 0; a < 64; a++) add_entry(1'b1, 6'(a), 1'b0, '0, '0);
  endfunction

  task automatic drive(input logic re, input logic [5:0] ra, input logic we,
                       input logic [5:0] wa, input logic [31:0] d);
    read   <= re;
    rd_adr <= ra;
    write  <= we;
    wr_adr <= wa;
    din    <= d;
  endtask

  initial begin
    reset <= 1'b1;
    drive(1'b0, '0, 1'b0, '0, '0);
    void'($urandom(32'ha540_6047));
    fill_table();
    cycle_limit = stim.size() + 200 + 16 + 50;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    // Ignored while the table initializes
    @(posedge clk);
    drive(1'b1, 6'd5, 1'b1, 6'd5, 32'hdead_beef);
    @(posedge clk);
    drive(1'b0, '0, 1'b0, '0, '0);
    do @(negedge clk); while (ready !== 1'b1);
    foreach (stim[i]) begin
      @(posedge clk);
      drive(stim[i].rd_en, stim[i].rd_adr, stim[i].wr_en, stim[i].wr_adr, stim[i].din);
    end
    repeat (200) begin
      @(posedge clk);
      drive(1'($urandom()), 6'($urandom()), 1'($urandom()), 6'($urandom()), $urandom());
    end
    @(posedge clk);
    drive(1'b0, '0, 1'b0, '0, '0);
    repeat (3) @(posedge clk);
    $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
    if (error_cnt == 0 && check_cnt > 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

endmodule
